// ==== compile.f ====
csr_pkg.sv
csr_irq.sv
csr_regfile.sv
csr_exec_fsm.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv

// ==== csr_checker.sv ====
// Compares rd write pulses and exported CSRs with expectations pushed by the testbench
// Assumes one instruction in flight; exports are checked one cycle after each pulse
module csr_checker (
    input  logic               aclk,
    input  logic               rd_wr_en,
    input  csr_pkg::reg_addr_t rd_wr_addr,
    input  csr_pkg::xlen_t     rd_wr_val,
    input  csr_pkg::xlen_t     mtvec,
    input  csr_pkg::xlen_t     mepc,
    input  csr_pkg::xlen_t     mstatus
);

    import csr_pkg::*;

    int    value_errors = 0;
    int    other_errors = 0;
    string test_name    = "none";

    // One entry per outstanding instruction
    reg_addr_t exp_addr_q   [$];
    xlen_t     exp_val_q    [$];
    xlen_t     exp_tvec_q   [$];
    xlen_t     exp_epc_q    [$];
    xlen_t     exp_status_q [$];

    // Popped entry, exports wait one cycle for the CSR write
    reg_addr_t exp_addr;
    xlen_t     exp_val;
    xlen_t     held_tvec;
    xlen_t     held_epc;
    xlen_t     held_status;
    logic      export_due = 1'b0;

    task automatic expect_write(input string name, input reg_addr_t addr, input xlen_t val,
                                input xlen_t tvec, input xlen_t epc, input xlen_t status);
        test_name = name;
        exp_addr_q.push_back(addr);
        exp_val_q.push_back(val);
        exp_tvec_q.push_back(tvec);
        exp_epc_q.push_back(epc);
        exp_status_q.push_back(status);
    endtask

    task automatic check_value(input string name, input string what, input xlen_t exp,
                               input xlen_t act);
        if (exp !== act) begin
            value_errors++;
            $display("error %s %s expected %08h actual %08h", name, what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    // Nothing queued and no export check left
    function automatic logic idle();
        return (exp_addr_q.size() == 0) && !export_due;
    endfunction

    // Mid-cycle sampling, DUT outputs are all registered
    always @(negedge aclk) begin
        if (export_due) begin
            check_value(test_name, "mtvec", held_tvec, mtvec);
            check_value(test_name, "mepc", held_epc, mepc);
            check_value(test_name, "mstatus", held_status, mstatus);
            export_due = 1'b0;
        end
        if (rd_wr_en === 1'b1) begin
            if (exp_addr_q.size() == 0) begin
                report_failure("rd write pulse seen with no instruction outstanding");
            end else begin
                exp_addr    = exp_addr_q.pop_front();
                exp_val     = exp_val_q.pop_front();
                held_tvec   = exp_tvec_q.pop_front();
                held_epc    = exp_epc_q.pop_front();
                held_status = exp_status_q.pop_front();
                check_value(test_name, "rd_wr_addr", xlen_t'(exp_addr), xlen_t'(rd_wr_addr));
                check_value(test_name, "rd_wr_val", exp_val, rd_wr_val);
                export_due = 1'b1;
            end
        end
    end

endmodule

// ==== csr_exec_fsm.sv ====
// One instruction in flight; next acceptance three edges after the previous one
// instbus and rs1_val must stay stable while valid is high
module csr_exec_fsm (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      valid,
    output logic                      ready,
    input  logic [csr_pkg::INST_W-1:0] instbus,
    output csr_pkg::reg_addr_t        rs1_addr,
    input  csr_pkg::xlen_t            rs1_val,
    output logic                      rd_wr_en,
    output csr_pkg::reg_addr_t        rd_wr_addr,
    output csr_pkg::xlen_t            rd_wr_val,
    output logic                      rd_req,
    output csr_pkg::csr_addr_t        rd_addr,
    input  csr_pkg::xlen_t            old_val,
    output logic                      csr_wren,
    output csr_pkg::csr_addr_t        csr_waddr,
    output csr_pkg::xlen_t            csr_wdata
);

    import csr_pkg::*;

    typedef enum logic {
        IDLE,
        COMPUTE
    } state_t;

    state_t    state;
    logic      accept;

    // Live instruction fields
    csr_op_t   funct3;
    reg_addr_t rd_field;

    // Operands held from acceptance
    csr_op_t   funct3_q;
    csr_addr_t csr_q;
    reg_addr_t rs1_q;
    xlen_t     rs1_val_q;

    // Compute results
    xlen_t     mask;
    xlen_t     new_val;
    logic      csr_we;
    logic      rd_we;

    //////////////////////////////
    // Field split
    //////////////////////////////

    assign funct3   = csr_op_t'(instbus[FUNCT3_LSB +: FUNCT3_W]);
    assign rd_field = instbus[RD_LSB +: REG_ADDR_W];
    assign rs1_addr = instbus[RS1_LSB +: REG_ADDR_W];
    assign rd_addr  = instbus[CSR_LSB +: CSR_ADDR_W];

    assign accept = (state == IDLE) && valid && ready;
    // CSR read launched on the acceptance edge
    assign rd_req = accept;

    // Address stays put until the next acceptance
    assign csr_waddr = csr_q;

    // Immediate forms have funct3[2] set
    assign mask = funct3_q[2] ? xlen_t'(rs1_q) : rs1_val_q;

    always_comb begin
        new_val = old_val;
        csr_we  = 1'b0;
        rd_we   = 1'b1;
        case (funct3_q)
            CSRRW, CSRRWI: begin
                new_val = mask;
                csr_we  = 1'b1;
            end
            CSRRS, CSRRSI: begin
                new_val = old_val | mask;
                // x0 or zimm 0 means read only
                csr_we  = (rs1_q != '0);
            end
            CSRRC, CSRRCI: begin
                new_val = old_val & ~mask;
                csr_we  = (rs1_q != '0);
            end
            default: begin
                rd_we = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Control
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            ready    <= 1'b0;
            rd_wr_en <= 1'b0;
            csr_wren <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    rd_wr_en <= 1'b0;
                    csr_wren <= 1'b0;
                    ready    <= 1'b1;
                    if (accept) begin
                        ready <= 1'b0;
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    // ready stays low through the write cycle
                    rd_wr_en <= rd_we;
                    csr_wren <= csr_we;
                    state    <= IDLE;
                end
            endcase
        end
    end

    // Operand and result payload
    always_ff @(posedge aclk) begin
        if (accept) begin
            funct3_q   <= funct3;
            csr_q      <= rd_addr;
            rs1_q      <= rs1_addr;
            rs1_val_q  <= rs1_val;
            rd_wr_addr <= rd_field;
        end
        if (state == COMPUTE) begin
            rd_wr_val <= old_val;
            csr_wdata <= new_val;
        end
    end

endmodule

// ==== csr_irq.sv ====
// Interrupt lines are asynchronous; three edges from line to pending bit
// A line held high blocks CSR writes to mip
module csr_irq (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               ext_irq,
    input  logic               timer_irq,
    input  logic               sw_irq,
    input  csr_pkg::xlen_t     mie,
    input  logic               csr_wren,
    input  csr_pkg::csr_addr_t csr_waddr,
    input  csr_pkg::xlen_t     csr_wdata,
    output csr_pkg::xlen_t     mip,
    output logic               meip,
    output logic               mtip,
    output logic               msip
);

    import csr_pkg::*;

    // Line order: ext, timer, sw
    logic [2:0]                 irq_lines;
    logic [SYNC_DEPTH-1:0][2:0] sync_q;
    logic [2:0]                 irq_sync;

    assign irq_lines = {ext_irq, timer_irq, sw_irq};
    assign irq_sync  = sync_q[SYNC_DEPTH-1];

    // Shift chain, one row per stage
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_DEPTH-2:0], irq_lines};
        end
    end

    // Pending bits, line activity wins over software writes
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mip <= '0;
        end else if (|irq_sync) begin
            if (irq_sync[2] && mie[IRQ_MEI]) begin
                mip[IRQ_MEI] <= 1'b1;
            end
            if (irq_sync[1] && mie[IRQ_MTI]) begin
                mip[IRQ_MTI] <= 1'b1;
            end
            if (irq_sync[0] && mie[IRQ_MSI]) begin
                mip[IRQ_MSI] <= 1'b1;
            end
        end else if (csr_wren && (csr_waddr == CSR_MIP)) begin
            mip <= csr_wdata & MIP_WMASK;
        end
    end

    assign meip = mip[IRQ_MEI];
    assign mtip = mip[IRQ_MTI];
    assign msip = mip[IRQ_MSI];

endmodule

// ==== csr_pkg.sv ====
// Shared definitions for the machine-mode CSR unit. XLEN is fixed at 32, no 64/128-bit variants
// Only the M-mode registers listed here exist, anything else reads zero
package csr_pkg;

    //////////////////////////////
    // Widths and types
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int INST_W     = 32;
    localparam int FUNCT3_W   = 3;

    typedef logic [XLEN-1:0]       xlen_t;
    // Integer register index, also carries zimm
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Instruction field positions, zimm sits in the rs1 slot
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int CSR_LSB    = 20;

    // Zicsr funct3 encodings, 0 and 4 are unknown
    typedef enum logic [FUNCT3_W-1:0] {
        CSRRW  = 3'd1,
        CSRRS  = 3'd2,
        CSRRC  = 3'd3,
        CSRRWI = 3'd5,
        CSRRSI = 3'd6,
        CSRRCI = 3'd7
    } csr_op_t;

    //////////////////////////////
    // CSR address map
    //////////////////////////////

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MHARTID  = 12'hF14;

    // Writable mstatus bits: 31, 22:11, 8:7, 5:3, 1:0
    localparam xlen_t MSTATUS_WMASK = 32'h807F_F9BB;
    // MXL = 1 (32-bit), I base ISA only
    localparam xlen_t MISA_VALUE    = 32'h4000_0100;
    localparam xlen_t MHART_ID      = 32'h0000_0000;

    // Interrupt bit positions in mie and mip
    localparam int IRQ_MSI = 3;
    localparam int IRQ_MTI = 7;
    localparam int IRQ_MEI = 11;

    localparam xlen_t MIP_WMASK = 32'h0000_0888;

    // Flops per asynchronous interrupt line
    localparam int SYNC_DEPTH = 2;

endpackage

// ==== csr_regfile.sv ====
// Software-visible M-mode CSRs; only CSR instructions write them, no trap-side writes
// Unmapped addresses read zero and ignore writes, as do misa and mhartid
module csr_regfile (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               rd_req,
    input  csr_pkg::csr_addr_t rd_addr,
    output csr_pkg::xlen_t     old_val,
    input  logic               csr_wren,
    input  csr_pkg::csr_addr_t csr_waddr,
    input  csr_pkg::xlen_t     csr_wdata,
    input  csr_pkg::xlen_t     mip,
    output csr_pkg::xlen_t     mie,
    output csr_pkg::xlen_t     mtvec,
    output csr_pkg::xlen_t     mepc,
    output csr_pkg::xlen_t     mstatus
);

    import csr_pkg::*;

    // Internal-only CSRs
    xlen_t mscratch;
    xlen_t mcause;
    xlen_t mtval;

    // Read mux output
    xlen_t rd_mux;

    //////////////////////////////
    // Write decode
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (csr_wren) begin
            case (csr_waddr)
                CSR_MSTATUS: begin
                    // WPRI and unsupported fields stay zero
                    mstatus <= csr_wdata & MSTATUS_WMASK;
                end
                CSR_MIE: begin
                    mie <= csr_wdata;
                end
                CSR_MTVEC: begin
                    mtvec <= csr_wdata;
                end
                CSR_MSCRATCH: begin
                    mscratch <= csr_wdata;
                end
                CSR_MEPC: begin
                    // IALIGN = 32, low two bits always zero
                    mepc <= {csr_wdata[XLEN-1:2], 2'b00};
                end
                CSR_MCAUSE: begin
                    mcause <= csr_wdata;
                end
                CSR_MTVAL: begin
                    mtval <= csr_wdata;
                end
                // mip lives in the interrupt block
                default: begin
                end
            endcase
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    always_comb begin
        case (rd_addr)
            CSR_MSTATUS:  rd_mux = mstatus;
            CSR_MISA:     rd_mux = MISA_VALUE;
            CSR_MIE:      rd_mux = mie;
            CSR_MTVEC:    rd_mux = mtvec;
            CSR_MSCRATCH: rd_mux = mscratch;
            CSR_MEPC:     rd_mux = mepc;
            CSR_MCAUSE:   rd_mux = mcause;
            CSR_MTVAL:    rd_mux = mtval;
            CSR_MIP:      rd_mux = mip;
            CSR_MHARTID:  rd_mux = MHART_ID;
            default:      rd_mux = '0;
        endcase
    end

    // One edge of read latency
    always_ff @(posedge aclk) begin
        if (rd_req) begin
            old_val <= rd_mux;
        end
    end

endmodule

// ==== csr_unit.sv ====
// Machine-mode Zicsr unit for an RV32 core, one instruction in flight
// Upstream decode sends only CSR instructions, the opcode field is not checked
module csr_unit (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       valid,
    output logic                       ready,
    input  logic [csr_pkg::INST_W-1:0] instbus,
    output csr_pkg::reg_addr_t         rs1_addr,
    input  csr_pkg::xlen_t             rs1_val,
    output logic                       rd_wr_en,
    output csr_pkg::reg_addr_t         rd_wr_addr,
    output csr_pkg::xlen_t             rd_wr_val,
    input  logic                       ext_irq,
    input  logic                       timer_irq,
    input  logic                       sw_irq,
    output csr_pkg::xlen_t             mtvec,
    output csr_pkg::xlen_t             mepc,
    output csr_pkg::xlen_t             mstatus,
    output logic                       meip,
    output logic                       mtip,
    output logic                       msip
);

    import csr_pkg::*;

    // Read request and returned value
    logic      rd_req;
    csr_addr_t rd_addr;
    xlen_t     old_val;

    // Write request, shared by regfile and mip
    logic      csr_wren;
    csr_addr_t csr_waddr;
    xlen_t     csr_wdata;

    xlen_t     mie;
    xlen_t     mip;

    csr_exec_fsm u_exec (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .old_val    (old_val),
        .csr_wren   (csr_wren),
        .csr_waddr  (csr_waddr),
        .csr_wdata  (csr_wdata)
    );

    csr_regfile u_regfile (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .old_val   (old_val),
        .csr_wren  (csr_wren),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .mip       (mip),
        .mie       (mie),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .mstatus   (mstatus)
    );

    csr_irq u_irq (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .sw_irq    (sw_irq),
        .mie       (mie),
        .csr_wren  (csr_wren),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata),
        .mip       (mip),
        .meip      (meip),
        .mtip      (mtip),
        .msip      (msip)
    );

endmodule

// ==== tb_csr_unit.sv ====
// Testbench for csr_unit; rd writes are not fed back into the integer-register model
// Interrupt lines change on the falling edge and reach mip through the DUT synchronizers
module tb_csr_unit;

    import csr_pkg::*;

    localparam int TIMEOUT = 40;

    logic              aclk;
    logic              aresetn;
    logic              valid;
    logic              ready;
    logic [INST_W-1:0] instbus;
    reg_addr_t         rs1_addr;
    xlen_t             rs1_val;
    logic              rd_wr_en;
    reg_addr_t         rd_wr_addr;
    xlen_t             rd_wr_val;
    logic              ext_irq;
    logic              timer_irq;
    logic              sw_irq;
    xlen_t             mtvec;
    xlen_t             mepc;
    xlen_t             mstatus;
    logic              meip;
    logic              mtip;
    logic              msip;

    // Integer registers, x0 stays zero
    xlen_t regs [32];
    xlen_t rng;

    // Model CSR file
    xlen_t m_mstatus;
    xlen_t m_mie;
    xlen_t m_mtvec;
    xlen_t m_mscratch;
    xlen_t m_mepc;
    xlen_t m_mcause;
    xlen_t m_mtval;
    xlen_t m_mip;

    always #50 aclk = ~aclk;

    // Register query answered in the same cycle
    assign rs1_val = regs[rs1_addr];

    csr_unit csr_unit_inst (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .valid      (valid),
        .ready      (ready),
        .instbus    (instbus),
        .rs1_addr   (rs1_addr),
        .rs1_val    (rs1_val),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .ext_irq    (ext_irq),
        .timer_irq  (timer_irq),
        .sw_irq     (sw_irq),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .mstatus    (mstatus),
        .meip       (meip),
        .mtip       (mtip),
        .msip       (msip)
    );

    csr_checker csr_checker_inst (
        .aclk       (aclk),
        .rd_wr_en   (rd_wr_en),
        .rd_wr_addr (rd_wr_addr),
        .rd_wr_val  (rd_wr_val),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .mstatus    (mstatus)
    );

    //////////////////////////////
    // Helpers and reference
    //////////////////////////////

    function automatic xlen_t next_random(input xlen_t x);
        xlen_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0..6 writable, 7 mip, 8..9 read-only, rest unmapped
    function automatic csr_addr_t csr_by_index(input int k);
        case (k)
            0: return CSR_MSTATUS;
            1: return CSR_MIE;
            2: return CSR_MTVEC;
            3: return CSR_MSCRATCH;
            4: return CSR_MEPC;
            5: return CSR_MCAUSE;
            6: return CSR_MTVAL;
            7: return CSR_MIP;
            8: return CSR_MISA;
            9: return CSR_MHARTID;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic csr_op_t op_by_index(input int k);
        case (k)
            0: return CSRRW;
            1: return CSRRS;
            2: return CSRRC;
            3: return CSRRWI;
            4: return CSRRSI;
            default: return CSRRCI;
        endcase
    endfunction

    // Returns the old CSR value and applies the write to the model
    function automatic xlen_t expected_rd(input csr_op_t op, input csr_addr_t csr,
                                          input reg_addr_t src, input xlen_t src_val);
        xlen_t old;
        xlen_t mask;
        xlen_t nv;
        logic  wr;
        case (csr)
            CSR_MSTATUS:  old = m_mstatus;
            CSR_MISA:     old = MISA_VALUE;
            CSR_MIE:      old = m_mie;
            CSR_MTVEC:    old = m_mtvec;
            CSR_MSCRATCH: old = m_mscratch;
            CSR_MEPC:     old = m_mepc;
            CSR_MCAUSE:   old = m_mcause;
            CSR_MTVAL:    old = m_mtval;
            CSR_MIP:      old = m_mip;
            CSR_MHARTID:  old = MHART_ID;
            default:      old = '0;
        endcase
        // Immediate forms take zimm from the rs1 field
        mask = (op == CSRRWI || op == CSRRSI || op == CSRRCI) ? xlen_t'(src) : src_val;
        wr   = 1'b1;
        nv   = mask;
        if (op == CSRRS || op == CSRRSI) begin
            nv = old | mask;
            wr = (src != '0);
        end else if (op == CSRRC || op == CSRRCI) begin
            nv = old & ~mask;
            wr = (src != '0);
        end
        if (wr) begin
            case (csr)
                CSR_MSTATUS:  m_mstatus = nv & MSTATUS_WMASK;
                CSR_MIE:      m_mie = nv;
                CSR_MTVEC:    m_mtvec = nv;
                CSR_MSCRATCH: m_mscratch = nv;
                CSR_MEPC:     m_mepc = nv & ~xlen_t'(3);
                CSR_MCAUSE:   m_mcause = nv;
                CSR_MTVAL:    m_mtval = nv;
                // Interrupt lines are quiet whenever mip is written here
                CSR_MIP:      m_mip = nv & MIP_WMASK;
                default:      ;
            endcase
        end
        return old;
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic issue_instr(input string name, input csr_op_t op, input csr_addr_t csr,
                               input reg_addr_t src, input reg_addr_t rd);
        int    n;
        xlen_t exp_rd;
        n = 0;
        while (ready !== 1'b1 && n < TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (ready !== 1'b1) begin
            csr_checker_inst.report_failure({"timeout waiting for ready in ", name});
        end else begin
            exp_rd = expected_rd(op, csr, src, regs[src]);
            csr_checker_inst.expect_write(name, rd, exp_rd, m_mtvec, m_mepc, m_mstatus);
            instbus = {csr, src, op, rd, 7'b1110011};
            valid   = 1'b1;
            @(negedge aclk);
            valid = 1'b0;
            n = 0;
            while (!csr_checker_inst.idle() && n < TIMEOUT) begin
                @(posedge aclk);
                n++;
            end
            if (!csr_checker_inst.idle()) begin
                csr_checker_inst.report_failure({"rd write pulse missing in ", name});
            end
            @(negedge aclk);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int i;
        int k;
        int n;
        aclk       = 1'b0;
        aresetn    = 1'b0;
        valid      = 1'b0;
        instbus    = '0;
        ext_irq    = 1'b0;
        timer_irq  = 1'b0;
        sw_irq     = 1'b0;
        m_mstatus  = '0;
        m_mie      = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        m_mip      = '0;
        rng        = 32'h4287;
        regs[0]    = '0;
        for (i = 1; i < 32; i++) begin
            rng     = next_random(rng);
            regs[i] = rng;
        end
        // x1 holds the external interrupt bit alone
        regs[1] = xlen_t'(1) << IRQ_MEI;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // Reset values through CSRRS x0, unmapped address last
        for (k = 0; k < 11; k++) begin
            issue_instr($sformatf("reset_%03h", csr_by_index(k)), CSRRS, csr_by_index(k),
                        5'd0, 5'd10);
        end

        // Random ops, about one in eight with source x0 or zimm 0
        for (i = 0; i < 60; i++) begin
            rng = next_random(rng);
            issue_instr($sformatf("random_%0d", i), op_by_index(int'(rng[23:16] % 6)),
                        csr_by_index(int'(rng[31:24] % 7)),
                        (rng[7:5] == 3'd0) ? 5'd0 : rng[4:0], rng[12:8]);
        end

        // Read-only CSRs keep their value, rd still gets it
        for (k = 8; k < 10; k++) begin
            issue_instr($sformatf("ro_write_%03h", csr_by_index(k)), CSRRW, csr_by_index(k),
                        5'd5, 5'd11);
            issue_instr($sformatf("ro_read_%03h", csr_by_index(k)), CSRRS, csr_by_index(k),
                        5'd0, 5'd11);
        end

        // Only MEI enabled, timer and software lines must stay masked
        issue_instr("irq_enable", CSRRW, CSR_MIE, 5'd1, 5'd3);
        ext_irq   = 1'b1;
        timer_irq = 1'b1;
        sw_irq    = 1'b1;
        n = 0;
        while (meip !== 1'b1 && n < TIMEOUT) begin
            @(negedge aclk);
            n++;
        end
        if (meip !== 1'b1) begin
            csr_checker_inst.report_failure("meip never rose while ext_irq was held high");
        end
        m_mip[IRQ_MEI] = 1'b1;
        csr_checker_inst.check_value("irq_gate", "mtip", '0, xlen_t'(mtip));
        csr_checker_inst.check_value("irq_gate", "msip", '0, xlen_t'(msip));
        ext_irq   = 1'b0;
        timer_irq = 1'b0;
        sw_irq    = 1'b0;
        // Synchronizer drains in three edges
        repeat (SYNC_DEPTH + 1) @(negedge aclk);
        issue_instr("irq_clear", CSRRC, CSR_MIP, 5'd1, 5'd4);
        csr_checker_inst.check_value("irq_clear", "meip", '0, xlen_t'(meip));

        $display("errors: %0d value, %0d other", csr_checker_inst.value_errors,
                 csr_checker_inst.other_errors);
        if (csr_checker_inst.value_errors == 0 && csr_checker_inst.other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
